// ==== Bender.yml ====
package:
  name: datapath

sources:
  - rtl/datapath_pkg.sv
  - rtl/register_file_if.sv
  - rtl/register_file.sv
  - rtl/alu.sv
  - rtl/program_counter.sv
  - rtl/data_memory.sv
  - rtl/datapath.sv
  - target: simulation
    files:
      - tb/datapath_assertions.sv
      - tb/datapath_tb.sv

// ==== datapath.f ====
rtl/datapath_pkg.sv
rtl/register_file_if.sv
rtl/register_file.sv
rtl/alu.sv
rtl/program_counter.sv
rtl/data_memory.sv
rtl/datapath.sv
tb/datapath_assertions.sv
tb/datapath_tb.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire datapath_pkg::word_t         a,
    input  wire datapath_pkg::word_t         b,
    input  wire datapath_pkg::alu_function_t function_select,
    output      datapath_pkg::word_t         result,
    output      datapath_pkg::alu_status_t   flags
);
    import datapath_pkg::*;

    logic [2:0]  operation;
    logic        carry_in;
    logic        invert_b;
    word_t       b_operand;
    logic [64:0] sum;
    logic [5:0]  shift_amount;
    logic        carry;
    logic        overflow;
    logic        negative;
    logic        zero;

    // Function code fields
    assign operation = function_select[4:2];
    assign carry_in  = function_select[1];
    assign invert_b  = function_select[0];

    assign b_operand    = invert_b ? ~b : b;
    assign shift_amount = b[5:0];

    // Adder with carry out in bit 64
    assign sum = {1'b0, a} + {1'b0, b_operand} + {64'd0, carry_in};

    always_comb begin
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (operation)
            alu_op_and: begin
                result = a & b_operand;
            end
            alu_op_or: begin
                result = a | b_operand;
            end
            alu_op_xor: begin
                result = a ^ b_operand;
            end
            alu_op_add: begin
                result = sum[63:0];
                carry  = sum[64];
                // Signed overflow when both inputs share a sign the sum lacks
                overflow = (a[63] == b_operand[63]) && (sum[63] != a[63]);
            end
            alu_op_shift_left: begin
                result = a << shift_amount;
            end
            alu_op_shift_right: begin
                result = a >> shift_amount;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign negative = result[63];
    assign zero     = (result == '0);

    // overflow, carry, negative, zero
    assign flags = {overflow, carry, negative, zero};

endmodule

`default_nettype wire

// ==== rtl/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int address_width = 10
) (
    input  wire logic                     clock,
    input  wire logic [address_width-1:0] address,
    input  wire logic                     write,
    input  wire datapath_pkg::word_t      write_data,
    output      datapath_pkg::word_t      read_data
);
    import datapath_pkg::*;

    word_t memory [2**address_width];

    // Asynchronous read
    assign read_data = memory[address];

    always_ff @(posedge clock) begin
        if (write) begin
            memory[address] <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter int memory_address_width = 10
) (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire datapath_pkg::control_word_t control_word,
    input  wire datapath_pkg::word_t         immediate,
    output      logic [4:0]                  status,
    output      datapath_pkg::word_t         program_count
);
    import datapath_pkg::*;

    logic          bus_alu_enable;
    logic          alu_b_select;
    alu_function_t alu_function;
    logic          bus_register_b_enable;
    logic          register_write;
    logic          bus_memory_enable;
    logic          memory_write;
    logic          bus_pc_next_enable;
    pc_function_t  pc_function;
    logic          pc_input_select;
    logic          status_load;

    word_t       data_bus;
    word_t       alu_b;
    word_t       alu_result;
    alu_status_t alu_flags;
    alu_status_t status_register;
    word_t       memory_read_data;
    word_t       pc_input;
    word_t       pc_next;

    // Control word decode
    assign bus_alu_enable        = control_word[cw_bus_alu_enable_lsb];
    assign alu_b_select          = control_word[cw_alu_b_select_lsb];
    assign alu_function          = control_word[cw_alu_function_lsb +: 5];
    assign bus_register_b_enable = control_word[cw_bus_register_b_enable_lsb];
    assign register_write        = control_word[cw_register_write_lsb];
    assign bus_memory_enable     = control_word[cw_bus_memory_enable_lsb];
    assign memory_write          = control_word[cw_memory_write_lsb];
    assign bus_pc_next_enable    = control_word[cw_bus_pc_next_enable_lsb];
    assign pc_function           = control_word[cw_pc_function_lsb +: 2];
    assign pc_input_select       = control_word[cw_pc_input_select_lsb];
    assign status_load           = control_word[cw_status_load_lsb];

    register_file_if rf_bus ();

    assign rf_bus.select_a      = control_word[cw_select_a_lsb +: 5];
    assign rf_bus.select_b      = control_word[cw_select_b_lsb +: 5];
    assign rf_bus.write_address = control_word[cw_write_address_lsb +: 5];
    assign rf_bus.write         = register_write;
    assign rf_bus.write_data    = data_bus;

    register_file u_register_file (
        .clock (clock),
        .reset (reset),
        .port  (rf_bus)
    );

    assign alu_b = alu_b_select ? immediate : rf_bus.read_b;

    alu u_alu (
        .a               (rf_bus.read_a),
        .b               (alu_b),
        .function_select (alu_function),
        .result          (alu_result),
        .flags           (alu_flags)
    );

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            status_register <= '0;
        end else if (status_load) begin
            status_register <= alu_flags;
        end
    end

    // Stored flags plus the live zero flag
    assign status = {status_register, alu_flags[0]};

    // Byte address from the ALU, word index into memory
    data_memory #(
        .address_width (memory_address_width)
    ) u_data_memory (
        .clock      (clock),
        .address    (alu_result[3 +: memory_address_width]),
        .write      (memory_write),
        .write_data (data_bus),
        .read_data  (memory_read_data)
    );

    assign pc_input = pc_input_select ? immediate : rf_bus.read_a;

    program_counter u_program_counter (
        .clock       (clock),
        .reset       (reset),
        .pc_function (pc_function),
        .target      (pc_input),
        .pc          (program_count),
        .pc_next     (pc_next)
    );

    // Only one enable should be set; priority just keeps the bus defined
    always_comb begin
        if (bus_alu_enable) begin
            data_bus = alu_result;
        end else if (bus_register_b_enable) begin
            data_bus = rf_bus.read_b;
        end else if (bus_memory_enable) begin
            data_bus = memory_read_data;
        end else if (bus_pc_next_enable) begin
            data_bus = pc_next;
        end else begin
            data_bus = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/datapath_pkg.sv ====
`default_nettype none

package datapath_pkg;

    typedef logic [63:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [30:0] control_word_t;
    typedef logic [4:0]  alu_function_t;
    typedef logic [3:0]  alu_status_t;
    typedef logic [1:0]  pc_function_t;

    // Reads as zero, writes are dropped
    localparam reg_addr_t zero_register = 5'd31;

    // Control word field positions, from the top bit down
    localparam int cw_bus_alu_enable_lsb        = 30;
    localparam int cw_alu_b_select_lsb          = 29;
    localparam int cw_alu_function_lsb          = 24;
    localparam int cw_bus_register_b_enable_lsb = 23;
    localparam int cw_select_a_lsb              = 18;
    localparam int cw_select_b_lsb              = 13;
    localparam int cw_write_address_lsb         = 8;
    localparam int cw_register_write_lsb        = 7;
    localparam int cw_bus_memory_enable_lsb     = 6;
    localparam int cw_memory_write_lsb          = 5;
    localparam int cw_bus_pc_next_enable_lsb    = 4;
    localparam int cw_pc_function_lsb           = 2;
    localparam int cw_pc_input_select_lsb       = 1;
    localparam int cw_status_load_lsb           = 0;

    // ALU operation, bits 4 to 2 of the function code
    localparam logic [2:0] alu_op_and         = 3'd0;
    localparam logic [2:0] alu_op_or          = 3'd1;
    localparam logic [2:0] alu_op_xor         = 3'd2;
    localparam logic [2:0] alu_op_add         = 3'd3;
    localparam logic [2:0] alu_op_shift_left  = 3'd4;
    localparam logic [2:0] alu_op_shift_right = 3'd5;

    // Program counter update functions
    localparam pc_function_t pc_hold      = 2'd0;
    localparam pc_function_t pc_increment = 2'd1;
    localparam pc_function_t pc_load      = 2'd2;
    localparam pc_function_t pc_relative  = 2'd3;

endpackage

`default_nettype wire

// ==== rtl/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire datapath_pkg::pc_function_t pc_function,
    input  wire datapath_pkg::word_t        target,
    output      datapath_pkg::word_t        pc,
    output      datapath_pkg::word_t        pc_next
);
    import datapath_pkg::*;

    // Next sequential instruction, also used for links
    assign pc_next = pc + 64'd4;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else begin
            case (pc_function)
                pc_hold:      pc <= pc;
                pc_increment: pc <= pc_next;
                pc_load:      pc <= target;
                pc_relative:  pc <= pc + target;
                default:      pc <= pc;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input wire logic      clock,
    input wire logic      reset,
    register_file_if.owner port
);
    import datapath_pkg::*;

    word_t registers [32];

    // Two combinational read ports
    always_comb begin
        if (port.select_a == zero_register) begin
            port.read_a = '0;
        end else begin
            port.read_a = registers[port.select_a];
        end
    end

    always_comb begin
        if (port.select_b == zero_register) begin
            port.read_b = '0;
        end else begin
            port.read_b = registers[port.select_b];
        end
    end

    // Write lands at the end of the cycle, so a same-cycle read sees the old value
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (port.write && (port.write_address != zero_register)) begin
            registers[port.write_address] <= port.write_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/register_file_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface register_file_if;
    import datapath_pkg::*;

    reg_addr_t select_a;
    reg_addr_t select_b;
    reg_addr_t write_address;
    logic      write;
    word_t     write_data;
    word_t     read_a;
    word_t     read_b;

    modport owner (
        input  select_a, select_b, write_address, write, write_data,
        output read_a, read_b
    );

    modport user (
        output select_a, select_b, write_address, write, write_data,
        input  read_a, read_b
    );

endinterface

`default_nettype wire

// ==== tb/datapath_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath_assertions (
    input wire logic                       clock,
    input wire logic                       reset,
    input wire logic [3:0]                 bus_enables,
    input wire datapath_pkg::reg_addr_t    select_a,
    input wire datapath_pkg::word_t        read_a,
    input wire datapath_pkg::pc_function_t pc_function,
    input wire datapath_pkg::word_t        program_count
);
    import datapath_pkg::*;

    int failure_count = 0;

    single_bus_driver: assert property (@(posedge clock) disable iff (reset)
        $onehot0(bus_enables))
    else begin
        failure_count++;
        $error("More than one data bus enable is active");
    end

    zero_register_read: assert property (@(posedge clock)
        (select_a == 5'd31) |-> (read_a == '0))
    else begin
        failure_count++;
        $error("Register 31 read port A is not zero");
    end

    pc_after_reset: assert property (@(posedge clock)
        ($fell(reset) && pc_function == pc_hold) |=> (program_count == '0))
    else begin
        failure_count++;
        $error("PC is not zero after reset release");
    end

    pc_increment_step: assert property (@(posedge clock) disable iff (reset)
        (pc_function == pc_increment) |=> (program_count == $past(program_count) + 64'd4))
    else begin
        failure_count++;
        $error("PC did not advance by 4 after increment");
    end

endmodule

bind datapath datapath_assertions u_assertions (
    .clock         (clock),
    .reset         (reset),
    .bus_enables   ({bus_alu_enable, bus_register_b_enable, bus_memory_enable,
                     bus_pc_next_enable}),
    .select_a      (rf_bus.select_a),
    .read_a        (rf_bus.read_a),
    .pc_function   (pc_function),
    .program_count (program_count)
);

`default_nettype wire

// ==== tb/datapath_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath_tb;
    import datapath_pkg::*;

    localparam int bus_none = 0;
    localparam int bus_alu  = 1;
    localparam int bus_reg  = 2;
    localparam int bus_mem  = 3;
    localparam int bus_pc   = 4;
    localparam alu_function_t alu_add = {alu_op_add, 2'b00};
    localparam alu_function_t alu_sub = {alu_op_add, 2'b11};
    // Reset plus all tests take about 85 cycles
    localparam int cycle_limit = 2 * 90;

    logic          clock = 1'b0;
    logic          reset;
    control_word_t control_word;
    word_t         immediate;
    logic [4:0]    status;
    word_t         program_count;

    word_t       model_regs [32];
    word_t       model_mem [1024];
    word_t       model_pc;
    alu_status_t model_status;
    int          seed = 32;
    int          cycle_count = 0;

    datapath #(
        .memory_address_width (10)
    ) DUT (
        .clock         (clock),
        .reset         (reset),
        .control_word  (control_word),
        .immediate     (immediate),
        .status        (status),
        .program_count (program_count)
    );

    always #4 clock = ~clock;

    // Stops at the first failed assertion or when the run takes too long
    always @(posedge clock) begin
        cycle_count++;
        if (DUT.u_assertions.failure_count != 0) begin
            $display("A datapath assertion failed");
            $display(">>> FAIL");
            $fatal(1, "Assertion failure");
        end else if (cycle_count > cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "Timeout");
        end
    end

    task automatic check(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic word_t reg_value(input reg_addr_t r);
        return (r == 5'd31) ? '0 : model_regs[r];
    endfunction

    // Reference ALU following the function code rules
    task automatic model_alu(input word_t a, input word_t b, input alu_function_t fn,
                             output word_t result, output alu_status_t flags);
        word_t       operand;
        logic [64:0] total;
        operand = fn[0] ? ~b : b;
        total   = {1'b0, a} + {1'b0, operand} + fn[1];
        flags   = '0;
        case (fn[4:2])
            alu_op_and:         result = a & operand;
            alu_op_or:          result = a | operand;
            alu_op_xor:         result = a ^ operand;
            alu_op_add: begin
                result   = total[63:0];
                flags[2] = total[64];
                flags[3] = (a[63] & operand[63] & ~result[63])
                         | (~a[63] & ~operand[63] & result[63]);
            end
            alu_op_shift_left:  result = a << b[5:0];
            alu_op_shift_right: result = a >> b[5:0];
            default:            result = '0;
        endcase
        flags[1] = result[63];
        flags[0] = (result == '0);
    endtask

    // Builds the control word, applies it for one cycle and advances the model
    task automatic run_cycle(input int bus, input logic b_imm, input alu_function_t fn,
                             input reg_addr_t sel_a, input reg_addr_t sel_b,
                             input reg_addr_t wr_addr, input logic reg_wr, input logic mem_wr,
                             input pc_function_t pc_fn, input logic pc_imm,
                             input logic st_load, input word_t imm);
        control_word_t cw;
        word_t         a;
        word_t         result;
        word_t         bus_value;
        alu_status_t   flags;
        cw = '0;
        cw[cw_bus_alu_enable_lsb]        = (bus == bus_alu);
        cw[cw_alu_b_select_lsb]          = b_imm;
        cw[cw_alu_function_lsb +: 5]     = fn;
        cw[cw_bus_register_b_enable_lsb] = (bus == bus_reg);
        cw[cw_select_a_lsb +: 5]         = sel_a;
        cw[cw_select_b_lsb +: 5]         = sel_b;
        cw[cw_write_address_lsb +: 5]    = wr_addr;
        cw[cw_register_write_lsb]        = reg_wr;
        cw[cw_bus_memory_enable_lsb]     = (bus == bus_mem);
        cw[cw_memory_write_lsb]          = mem_wr;
        cw[cw_bus_pc_next_enable_lsb]    = (bus == bus_pc);
        cw[cw_pc_function_lsb +: 2]      = pc_fn;
        cw[cw_pc_input_select_lsb]       = pc_imm;
        cw[cw_status_load_lsb]           = st_load;
        a = reg_value(sel_a);
        model_alu(a, b_imm ? imm : reg_value(sel_b), fn, result, flags);
        case (bus)
            bus_alu: bus_value = result;
            bus_reg: bus_value = reg_value(sel_b);
            bus_mem: bus_value = model_mem[result[12:3]];
            bus_pc:  bus_value = model_pc + 64'd4;
            default: bus_value = '0;
        endcase
        @(posedge clock);
        control_word <= cw;
        immediate    <= imm;
        @(negedge clock);
        check(program_count, model_pc, "program count");
        check(status, {model_status, flags[0]}, "status");
        // State changes at the edge that ends this cycle
        if (reg_wr && wr_addr != 5'd31) model_regs[wr_addr] = bus_value;
        if (mem_wr) model_mem[result[12:3]] = bus_value;
        if (st_load) model_status = flags;
        case (pc_fn)
            pc_increment: model_pc = model_pc + 64'd4;
            pc_load:      model_pc = pc_imm ? imm : a;
            pc_relative:  model_pc = model_pc + (pc_imm ? imm : a);
            default:      model_pc = model_pc;
        endcase
    endtask

    task automatic idle();
        run_cycle(bus_none, 0, '0, '0, '0, '0, 0, 0, pc_hold, 0, 0, '0);
    endtask

    // r = r31 | immediate
    task automatic load_reg(input reg_addr_t r, input word_t value);
        run_cycle(bus_alu, 1, {alu_op_or, 2'b00}, 5'd31, '0, r, 1, 0, pc_hold, 0, 0, value);
    endtask

    // Loads the PC from register r, checks it, then puts the PC back
    task automatic read_reg(input reg_addr_t r, input word_t expected);
        word_t saved_pc;
        saved_pc = model_pc;
        run_cycle(bus_none, 0, '0, r, '0, '0, 0, 0, pc_load, 0, 0, '0);
        run_cycle(bus_none, 0, '0, '0, '0, '0, 0, 0, pc_load, 1, 0, saved_pc);
        check(program_count, expected, $sformatf("register %0d read back", r));
    endtask

    task automatic reset_state();
        idle();
        check(program_count, '0, "program count after reset");
        check(status, 5'b00001, "status after reset");
    endtask

    task automatic register_write_read();
        word_t values [7];
        for (int r = 1; r <= 6; r++) begin
            values[r] = {$random(seed), $random(seed)};
            load_reg(reg_addr_t'(r), values[r]);
        end
        for (int r = 1; r <= 6; r++) begin
            read_reg(reg_addr_t'(r), values[r]);
        end
        load_reg(5'd31, {$random(seed), $random(seed)});
        read_reg(5'd31, '0);
    endtask

    task automatic alu_operations();
        alu_function_t codes [7];
        codes = '{{alu_op_and, 2'b00}, {alu_op_or, 2'b00}, {alu_op_xor, 2'b00}, alu_add,
                  alu_sub, {alu_op_shift_left, 2'b00}, {alu_op_shift_right, 2'b00}};
        for (int i = 0; i < 7; i++) begin
            run_cycle(bus_alu, 0, codes[i], 5'd1, 5'd2, 5'd10, 1, 0, pc_hold, 0, 0, '0);
            read_reg(5'd10, model_regs[10]);
        end
    endtask

    task automatic status_flags();
        load_reg(5'd5, 64'd5);
        load_reg(5'd6, 64'd100);
        load_reg(5'd7, 64'h7fff_ffff_ffff_ffff);
        load_reg(5'd8, 64'd1);
        run_cycle(bus_none, 0, alu_sub, 5'd5, 5'd5, '0, 0, 0, pc_hold, 0, 1, '0);
        idle();
        check(status[4:1], 4'b0101, "flags of equal subtract");
        run_cycle(bus_none, 0, alu_sub, 5'd5, 5'd6, '0, 0, 0, pc_hold, 0, 1, '0);
        idle();
        check(status[4:1], 4'b0010, "flags of smaller minus larger");
        run_cycle(bus_none, 0, alu_add, 5'd7, 5'd8, '0, 0, 0, pc_hold, 0, 1, '0);
        idle();
        check(status[4:1], 4'b1010, "flags of overflowing add");
        // Stored flags hold, live zero drops
        run_cycle(bus_none, 0, {alu_op_or, 2'b00}, 5'd7, 5'd8, '0, 0, 0, pc_hold, 0, 0, '0);
        check(status, 5'b10100, "status without status load");
        idle();
        check(status[4:1], 4'b1010, "stored flags after a cycle without status load");
    endtask

    task automatic memory_store_load();
        word_t first;
        word_t second;
        first  = {$random(seed), $random(seed)};
        second = {$random(seed), $random(seed)};
        load_reg(5'd20, 64'h100);
        load_reg(5'd21, first);
        load_reg(5'd22, second);
        run_cycle(bus_reg, 1, alu_add, 5'd20, 5'd21, '0, 0, 1, pc_hold, 0, 0, 64'd8);
        run_cycle(bus_reg, 1, alu_add, 5'd20, 5'd22, '0, 0, 1, pc_hold, 0, 0, 64'd16);
        run_cycle(bus_mem, 1, alu_add, 5'd20, '0, 5'd23, 1, 0, pc_hold, 0, 0, 64'd8);
        run_cycle(bus_mem, 1, alu_add, 5'd20, '0, 5'd24, 1, 0, pc_hold, 0, 0, 64'd16);
        read_reg(5'd23, first);
        read_reg(5'd24, second);
    endtask

    task automatic program_counter_steps();
        run_cycle(bus_none, 0, '0, '0, '0, '0, 0, 0, pc_increment, 0, 0, '0);
        idle();
        check(program_count, 64'h4, "program count after increment");
        run_cycle(bus_none, 0, '0, '0, '0, '0, 0, 0, pc_relative, 1, 0, 64'h100);
        idle();
        check(program_count, 64'h104, "program count after relative add");
        // Link writes the return address
        run_cycle(bus_pc, 0, '0, '0, '0, 5'd15, 1, 0, pc_increment, 0, 0, '0);
        idle();
        check(program_count, 64'h108, "program count after link");
        read_reg(5'd15, 64'h108);
    endtask

    initial begin
        reset        = 1'b1;
        control_word = '0;
        immediate    = '0;
        model_pc     = '0;
        model_status = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        reset_state();
        register_write_read();
        alu_operations();
        status_flags();
        memory_store_load();
        program_counter_steps();
        repeat (2) @(posedge clock);
        @(negedge clock);
        if (DUT.u_assertions.failure_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("Assertions failed during the run");
            $display(">>> FAIL");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

`default_nettype wire
